/* common/fetch_defines.svh */
/*
 * Address map and memory size for the fetch subsystem.
 * Vectors must be word aligned. The RAM depth must be a power of two
 * because the RAM index is taken straight from the address bits.
 */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// PC value right after reset
`define FETCH_BOOT_ADDR 32'h0000_0000
// Interrupt vector
`define FETCH_IRQ_ADDR 32'h0000_0100
// Debug vector
`define FETCH_DEBUG_ADDR 32'h0000_0200
// RAM size in 32-bit words, addresses wrap above it
`define RAM_DEPTH_WORDS 1024

`endif

/* common/bus_pkg.sv */
/*
 * Types for the shared pipelined Wishbone bus.
 * No err or rty lines: bus errors are not modelled.
 * sel is carried but masters always drive all ones.
 */
package bus_pkg;

  // One master's request toward the bus
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic        we;
    logic [3:0]  sel;
    logic        stb;
    logic        cyc;
  } wb_req_t;

  // Slave reply, stall is the pipelined back-pressure
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        stall;
  } wb_rsp_t;

  // Current bus owner
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_LSU,
    GRANT_FETCH
  } grant_e;

endpackage

/* common/core_pkg.sv */
/*
 * Core-side types: FSM state encodings and the decode handoff.
 * The fetch states keep the order of the original read machine.
 */
package core_pkg;

  // Instruction read machine
  typedef enum logic [2:0] {
    IDLE,
    MEMORY_STALL,
    REQUEST,
    MEMORY_WAIT,
    DONE,
    PIPELINE_STALL
  } fetch_state_e;

  // Data access machine
  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_STALL,
    LSU_WAIT,
    LSU_DONE
  } lsu_state_e;

  // Handed to decode with valid/ready
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
  } fetch_out_t;

endpackage

/* fetch/fetch_unit.sv */
/*
 * Instruction fetch bus master with program counter.
 * One 32-bit read in flight at a time, word reads only.
 * First fetch starts 2 cycles after rst_i falls.
 * Redirects (debug, irq, branch) update pc_q only; a fetch already
 * issued completes and is handed to decode as is.
 */
`include "fetch_defines.svh"

module fetch_unit (
  input  logic                clk_i,
  input  logic                rst_i,
  // Redirect requests
  input  logic                irq_i,
  input  logic                drq_i,
  input  logic                branch_i,
  input  logic [19:0]         boffset_i,
  // Bus master side
  output bus_pkg::wb_req_t    bus_req_o,
  input  bus_pkg::wb_rsp_t    bus_rsp_i,
  // Decode side
  input  logic                out_ready_i,
  output logic                out_valid_o,
  output core_pkg::fetch_out_t out_o
);

  core_pkg::fetch_state_e state_d, state_q;

  logic [31:0] pc_d, pc_q;
  logic [31:0] adr_d, adr_q;
  logic [31:0] instr_d, instr_q;
  logic        stb_d, stb_q;
  logic        cyc_d, cyc_q;
  logic        valid_d, valid_q;
  logic        rst_q, rst_qq;
  logic        start_pulse;
  logic        accept;

  // Falling edge of the delayed reset kicks off the first fetch
  assign start_pulse = rst_qq && !rst_q;
  // Decode takes the item
  assign accept = valid_q && out_ready_i;

  // Next PC with later lines taking priority
  always_comb begin : pc_update
    pc_d = pc_q;
    if (accept) begin
      pc_d = pc_q + 32'd4;
    end
    // Zero-extended relative branch
    if (branch_i) begin
      pc_d = pc_q + {12'h000, boffset_i};
    end
    if (irq_i) begin
      pc_d = `FETCH_IRQ_ADDR;
    end
    // Debug beats everything
    if (drq_i) begin
      pc_d = `FETCH_DEBUG_ADDR;
    end
  end

  always_comb begin : read_fsm
    state_d = state_q;
    adr_d   = adr_q;
    stb_d   = stb_q;
    cyc_d   = cyc_q;
    valid_d = valid_q;
    instr_d = instr_q;
    case (state_q)
      core_pkg::IDLE: begin
        if (start_pulse) begin
          adr_d   = pc_d;
          stb_d   = 1'b1;
          cyc_d   = 1'b1;
          state_d = core_pkg::REQUEST;
        end
      end
      core_pkg::REQUEST: begin
        // First cycle of stb is accepted unless stalled
        if (!bus_rsp_i.stall) begin
          stb_d   = 1'b0;
          state_d = core_pkg::MEMORY_WAIT;
        end else begin
          state_d = core_pkg::MEMORY_STALL;
        end
      end
      core_pkg::MEMORY_STALL: begin
        // Hold stb until the arbiter lets us through
        if (!bus_rsp_i.stall) begin
          stb_d   = 1'b0;
          state_d = core_pkg::MEMORY_WAIT;
        end
      end
      core_pkg::MEMORY_WAIT: begin
        if (bus_rsp_i.ack) begin
          instr_d = bus_rsp_i.dat;
          cyc_d   = 1'b0;
          valid_d = 1'b1;
          state_d = core_pkg::DONE;
        end
      end
      core_pkg::DONE, core_pkg::PIPELINE_STALL: begin
        if (accept) begin
          // Issue the next read right away from the updated PC
          valid_d = 1'b0;
          adr_d   = pc_d;
          stb_d   = 1'b1;
          cyc_d   = 1'b1;
          state_d = core_pkg::REQUEST;
        end else begin
          state_d = core_pkg::PIPELINE_STALL;
        end
      end
      default: begin
        state_d = core_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= core_pkg::IDLE;
      stb_q   <= 1'b0;
      cyc_q   <= 1'b0;
      valid_q <= 1'b0;
      pc_q    <= `FETCH_BOOT_ADDR;
    end else begin
      state_q <= state_d;
      stb_q   <= stb_d;
      cyc_q   <= cyc_d;
      valid_q <= valid_d;
      pc_q    <= pc_d;
    end
  end

  // Payload and reset history
  always_ff @(posedge clk_i) begin
    adr_q   <= adr_d;
    instr_q <= instr_d;
    rst_q   <= rst_i;
    rst_qq  <= rst_q;
  end

  assign bus_req_o = '{adr: adr_q, dat: 32'h0, we: 1'b0, sel: 4'hf,
                       stb: stb_q, cyc: cyc_q};

  assign out_valid_o = valid_q;
  // Issued address doubles as the instruction's PC
  assign out_o = '{instr: instr_q, pc: adr_q};

  a_stb_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_q |-> cyc_q);

  // A parked item keeps valid set until decode takes it
  a_valid_while_parked: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q inside {core_pkg::DONE, core_pkg::PIPELINE_STALL}) |-> valid_q);

endmodule

/* verilog/load_store_unit.sv */
/*
 * Single-word data load/store bus master.
 * Strobe to done is 3 cycles minimum, longer while fetch owns the bus.
 * A strobe while busy is dropped. Full-word access only.
 */
module load_store_unit (
  input  logic             clk_i,
  input  logic             rst_i,
  // Core side
  input  logic             lsu_req_i,
  input  logic             lsu_we_i,
  input  logic [31:0]      lsu_addr_i,
  input  logic [31:0]      lsu_wdata_i,
  output logic             lsu_done_o,
  output logic [31:0]      lsu_rdata_o,
  // Bus master side
  output bus_pkg::wb_req_t bus_req_o,
  input  bus_pkg::wb_rsp_t bus_rsp_i
);

  core_pkg::lsu_state_e state_q;

  logic        stb_q;
  logic        cyc_q;
  logic        we_q;
  logic [31:0] adr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= core_pkg::LSU_IDLE;
      stb_q   <= 1'b0;
      cyc_q   <= 1'b0;
    end else begin
      case (state_q)
        core_pkg::LSU_IDLE: begin
          if (lsu_req_i) begin
            stb_q   <= 1'b1;
            cyc_q   <= 1'b1;
            state_q <= core_pkg::LSU_STALL;
          end
        end
        // stb high until accepted
        core_pkg::LSU_STALL: begin
          if (!bus_rsp_i.stall) begin
            stb_q   <= 1'b0;
            state_q <= core_pkg::LSU_WAIT;
          end
        end
        core_pkg::LSU_WAIT: begin
          if (bus_rsp_i.ack) begin
            cyc_q   <= 1'b0;
            state_q <= core_pkg::LSU_DONE;
          end
        end
        // One cycle for the done pulse
        default: begin
          state_q <= core_pkg::LSU_IDLE;
        end
      endcase
    end
  end

  // Access captured on the strobe, read data on ack
  always_ff @(posedge clk_i) begin
    if (state_q == core_pkg::LSU_IDLE && lsu_req_i) begin
      we_q    <= lsu_we_i;
      adr_q   <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
    if (state_q == core_pkg::LSU_WAIT && bus_rsp_i.ack) begin
      rdata_q <= bus_rsp_i.dat;
    end
  end

  assign bus_req_o = '{adr: adr_q, dat: wdata_q, we: we_q, sel: 4'hf,
                       stb: stb_q, cyc: cyc_q};

  assign lsu_done_o  = (state_q == core_pkg::LSU_DONE);
  assign lsu_rdata_o = rdata_q;

  a_no_req_when_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_req_i |-> state_q == core_pkg::LSU_IDLE);

endmodule

/* verilog/bus_arbiter.sv */
/*
 * Fixed-priority arbiter for two pipelined Wishbone masters.
 * LSU wins ties. Ownership is kept until the owner drops cyc,
 * and a free bus is granted in the same cycle cyc rises.
 */
module bus_arbiter (
  input  logic             clk_i,
  input  logic             rst_i,
  input  bus_pkg::wb_req_t fetch_req_i,
  input  bus_pkg::wb_req_t lsu_req_i,
  input  bus_pkg::wb_rsp_t ram_rsp_i,
  output bus_pkg::wb_rsp_t fetch_rsp_o,
  output bus_pkg::wb_rsp_t lsu_rsp_o,
  output bus_pkg::wb_req_t ram_req_o
);

  bus_pkg::grant_e grant_q, owner;
  bus_pkg::wb_rsp_t blocked_rsp;

  // Current owner keeps the bus, otherwise pick a new one
  always_comb begin
    if (grant_q == bus_pkg::GRANT_LSU && lsu_req_i.cyc) begin
      owner = bus_pkg::GRANT_LSU;
    end else if (grant_q == bus_pkg::GRANT_FETCH && fetch_req_i.cyc) begin
      owner = bus_pkg::GRANT_FETCH;
    end else if (lsu_req_i.cyc) begin
      owner = bus_pkg::GRANT_LSU;
    end else if (fetch_req_i.cyc) begin
      owner = bus_pkg::GRANT_FETCH;
    end else begin
      owner = bus_pkg::GRANT_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      grant_q <= bus_pkg::GRANT_NONE;
    end else begin
      grant_q <= owner;
    end
  end

  always_comb begin
    case (owner)
      bus_pkg::GRANT_LSU:   ram_req_o = lsu_req_i;
      bus_pkg::GRANT_FETCH: ram_req_o = fetch_req_i;
      default:              ram_req_o = '0;
    endcase
  end

  // Non-owner is held off
  assign blocked_rsp = '{dat: ram_rsp_i.dat, ack: 1'b0, stall: 1'b1};

  assign fetch_rsp_o = (owner == bus_pkg::GRANT_FETCH) ? ram_rsp_i : blocked_rsp;
  assign lsu_rsp_o   = (owner == bus_pkg::GRANT_LSU) ? ram_rsp_i : blocked_rsp;

  // Ack goes back to whoever issued the accepted request
  a_fetch_ack_owner: assert property (@(posedge clk_i) disable iff (rst_i)
    fetch_rsp_o.ack |-> $past(owner == bus_pkg::GRANT_FETCH && ram_req_o.stb));
  a_lsu_ack_owner: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_rsp_o.ack |-> $past(owner == bus_pkg::GRANT_LSU && ram_req_o.stb));

endmodule

/* verilog/local_ram.sv */
/*
 * Word-addressed RAM behind the bus.
 * Never stalls, acks exactly one cycle after acceptance.
 * Address bits above the RAM index are ignored, so addresses wrap.
 */
`include "fetch_defines.svh"

module local_ram (
  input  logic             clk_i,
  input  logic             rst_i,
  input  bus_pkg::wb_req_t bus_req_i,
  output bus_pkg::wb_rsp_t bus_rsp_o
);

  localparam int unsigned IDX_W = $clog2(`RAM_DEPTH_WORDS);

  logic [31:0]      mem [`RAM_DEPTH_WORDS];
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             ack_q;
  logic [31:0]      rdata_q;

  // Byte address in, word index out
  assign idx    = bus_req_i.adr[IDX_W+1:2];
  assign accept = bus_req_i.cyc && bus_req_i.stb;

  // Per-byte write enables, read returns old contents
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (bus_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_req_i.sel[b]) begin
            mem[idx][8*b +: 8] <= bus_req_i.dat[8*b +: 8];
          end
        end
      end
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  assign bus_rsp_o = '{dat: rdata_q, ack: ack_q, stall: 1'b0};

endmodule

/* verilog/fetch_subsystem.sv */
/*
 * Fetch and load/store masters sharing one RAM through the arbiter.
 * Completion is marked by out_valid_o and lsu_done_o only.
 */
module fetch_subsystem (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 irq_i,
  input  logic                 drq_i,
  input  logic                 branch_i,
  input  logic [19:0]          boffset_i,
  input  logic                 out_ready_i,
  output logic                 out_valid_o,
  output core_pkg::fetch_out_t out_o,
  input  logic                 lsu_req_i,
  input  logic                 lsu_we_i,
  input  logic [31:0]          lsu_addr_i,
  input  logic [31:0]          lsu_wdata_i,
  output logic                 lsu_done_o,
  output logic [31:0]          lsu_rdata_o
);

  bus_pkg::wb_req_t fetch_bus_req, lsu_bus_req, ram_bus_req;
  bus_pkg::wb_rsp_t fetch_bus_rsp, lsu_bus_rsp, ram_bus_rsp;

  fetch_unit i_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .irq_i       (irq_i),
    .drq_i       (drq_i),
    .branch_i    (branch_i),
    .boffset_i   (boffset_i),
    .bus_req_o   (fetch_bus_req),
    .bus_rsp_i   (fetch_bus_rsp),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_o       (out_o)
  );

  load_store_unit i_lsu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .lsu_req_i   (lsu_req_i),
    .lsu_we_i    (lsu_we_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_done_o  (lsu_done_o),
    .lsu_rdata_o (lsu_rdata_o),
    .bus_req_o   (lsu_bus_req),
    .bus_rsp_i   (lsu_bus_rsp)
  );

  // LSU has priority on a free bus
  bus_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fetch_req_i (fetch_bus_req),
    .lsu_req_i   (lsu_bus_req),
    .ram_rsp_i   (ram_bus_rsp),
    .fetch_rsp_o (fetch_bus_rsp),
    .lsu_rsp_o   (lsu_bus_rsp),
    .ram_req_o   (ram_bus_req)
  );

  local_ram i_ram (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_req_i (ram_bus_req),
    .bus_rsp_o (ram_bus_rsp)
  );

endmodule

/* test/tb_fetch_subsystem.sv */
/*
 * Testbench for the fetch subsystem.
 * RAM is loaded through the load/store port, then the core is reset again
 * so the fetch stream starts from a known image. Memory contents survive reset.
 * Writes in the mixed phase stay in the upper half of the RAM while the
 * fetch stream runs in the lower half.
 */
`include "fetch_defines.svh"

module tb_fetch_subsystem;

  localparam int IDX_W = $clog2(`RAM_DEPTH_WORDS);
  // Rough cycle budget per phase
  localparam int TEST_CYCLES = 2 * 8 + (`RAM_DEPTH_WORDS * 2 + 64) * 6
                               + (64 + 200 + 100) * 10 + 17 * 20 + 60 * 10;
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  logic                 clk_i = 1'b0;
  logic                 rst_i;
  logic                 irq_i;
  logic                 drq_i;
  logic                 branch_i;
  logic [19:0]          boffset_i;
  logic                 out_ready_i;
  logic                 out_valid_o;
  core_pkg::fetch_out_t out_o;
  logic                 lsu_req_i;
  logic                 lsu_we_i;
  logic [31:0]          lsu_addr_i;
  logic [31:0]          lsu_wdata_i;
  logic                 lsu_done_o;
  logic [31:0]          lsu_rdata_o;

  // Expected RAM contents
  logic [31:0] image [`RAM_DEPTH_WORDS];

  int error_count = 0;
  int taken_count = 0;
  int load_count  = 0;
  int cycle_count = 0;

  // Stream model state
  logic [31:0]          model_pc;
  logic [31:0]          exp_pc;
  logic                 held_valid;
  core_pkg::fetch_out_t held_item;

  fetch_subsystem i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .irq_i       (irq_i),
    .drq_i       (drq_i),
    .branch_i    (branch_i),
    .boffset_i   (boffset_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .lsu_req_i   (lsu_req_i),
    .lsu_we_i    (lsu_we_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_done_o  (lsu_done_o),
    .lsu_rdata_o (lsu_rdata_o)
  );

  always #5 clk_i = ~clk_i;

  // Word index with the upper address bits dropped
  function automatic logic [IDX_W-1:0] img_idx(input logic [31:0] addr);
    return addr[IDX_W+1:2];
  endfunction

  // Expected PC register one cycle later by redirect priority
  function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic took,
                                          input logic br, input logic [19:0] off,
                                          input logic irq, input logic drq);
    if (drq) return `FETCH_DEBUG_ADDR;
    if (irq) return `FETCH_IRQ_ADDR;
    if (br) return pc + {12'h000, off};
    if (took) return pc + 32'd4;
    return pc;
  endfunction

  task automatic check_fetch(input string name, input core_pkg::fetch_out_t got,
                             input core_pkg::fetch_out_t exp);
    if (got.pc !== exp.pc) begin
      $display("[ERROR] %s.pc: got %h, expected %h", name, got.pc, exp.pc);
      error_count++;
    end
    if (got.instr !== exp.instr) begin
      $display("[ERROR] %s.instr: got %h, expected %h", name, got.instr, exp.instr);
      error_count++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_counts();
    $display("Summary: %0d errors, %0d instructions checked, %0d loads checked",
             error_count, taken_count, load_count);
  endtask

  // Inputs change 1 unit after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic apply_reset();
    rst_i       = 1'b1;
    out_ready_i = 1'b0;
    repeat (8) next_cycle();
    if (out_valid_o !== 1'b0 || lsu_done_o !== 1'b0 ||
        i_dut.fetch_bus_req.cyc !== 1'b0 || i_dut.fetch_bus_req.stb !== 1'b0 ||
        i_dut.lsu_bus_req.cyc !== 1'b0 || i_dut.lsu_bus_req.stb !== 1'b0) begin
      $display("Outputs or bus strobes were not low at the end of reset");
      error_count++;
    end
    rst_i = 1'b0;
  endtask

  // Strobe once and wait for the done pulse with an idle cycle after it
  task automatic lsu_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    lsu_req_i   = 1'b1;
    lsu_we_i    = we;
    lsu_addr_i  = addr;
    lsu_wdata_i = wdata;
    next_cycle();
    lsu_req_i = 1'b0;
    waited    = 1;
    while (lsu_done_o !== 1'b1) begin
      next_cycle();
      waited++;
    end
    if (waited < 3) begin
      $display("lsu_done_o came %0d cycles after the strobe, at least 3 expected",
               waited);
      error_count++;
    end
    rdata = lsu_rdata_o;
    next_cycle();
    if (lsu_done_o !== 1'b0) begin
      $display("lsu_done_o stayed high for more than one cycle");
      error_count++;
    end
  endtask

  task automatic lsu_read_check(input logic [31:0] addr);
    logic [31:0] rdata;
    lsu_access(1'b0, addr, 32'h0, rdata);
    check_word("lsu_rdata_o", rdata, image[img_idx(addr)]);
    load_count++;
  endtask

  task automatic fill_ram();
    logic [31:0] addr;
    logic [31:0] rdata;
    for (int i = 0; i < `RAM_DEPTH_WORDS; i++) begin
      addr = 32'(i) << 2;
      image[img_idx(addr)] = $urandom;
    end
    // Known words at the vectors
    image[img_idx(`FETCH_BOOT_ADDR)]  = 32'h0000_0013;
    image[img_idx(`FETCH_IRQ_ADDR)]   = 32'h3420_2573;
    image[img_idx(`FETCH_DEBUG_ADDR)] = 32'h7b20_2073;
    for (int i = 0; i < `RAM_DEPTH_WORDS; i++) begin
      addr = 32'(i) << 2;
      lsu_access(1'b1, addr, image[img_idx(addr)], rdata);
    end
  endtask

  // Runs until count more items were taken by the compare process
  task automatic stream_items(input int count, input logic random_ready);
    int target;
    target = taken_count + count;
    while (taken_count < target) begin
      out_ready_i = random_ready ? 1'($urandom) : 1'b1;
      next_cycle();
    end
    out_ready_i = 1'b0;
  endtask

  // Pulse on a held item and check where the following fetch lands
  task automatic redirect_pulse(input logic br, input logic irq, input logic drq);
    logic [19:0] off;
    logic [31:0] cur_pc;
    logic [31:0] target;
    off = 20'($urandom);
    out_ready_i = 1'b0;
    while (out_valid_o !== 1'b1) next_cycle();
    cur_pc    = out_o.pc;
    branch_i  = br;
    irq_i     = irq;
    drq_i     = drq;
    boffset_i = off;
    next_cycle();
    branch_i = 1'b0;
    irq_i    = 1'b0;
    drq_i    = 1'b0;
    if (drq) target = `FETCH_DEBUG_ADDR;
    else if (irq) target = `FETCH_IRQ_ADDR;
    else if (br) target = cur_pc + {12'h000, off};
    else target = cur_pc;
    // Accepting the held item adds 4
    target = target + 32'd4;
    out_ready_i = 1'b1;
    next_cycle();
    out_ready_i = 1'b0;
    while (out_valid_o !== 1'b1) next_cycle();
    check_word("out_o.pc", out_o.pc, target);
  endtask

  task automatic lsu_traffic(input int count);
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        we;
    for (int n = 0; n < count; n++) begin
      we    = 1'($urandom);
      addr  = $urandom & 32'hffff_fffc;
      wdata = $urandom;
      if (we) begin
        // Writes stay in the upper half away from the fetched code
        addr[IDX_W+1] = 1'b1;
        image[img_idx(addr)] = wdata;
        lsu_access(1'b1, addr, wdata, rdata);
      end else begin
        lsu_read_check(addr);
      end
      repeat ($urandom % 4) next_cycle();
    end
  endtask

  // Decisions seen at negedge apply at the next rising edge
  always @(negedge clk_i) begin : compare_stream
    logic                 took;
    core_pkg::fetch_out_t exp_item;
    if (rst_i) begin
      model_pc   = `FETCH_BOOT_ADDR;
      exp_pc     = `FETCH_BOOT_ADDR;
      held_valid = 1'b0;
    end else begin
      took = out_valid_o && out_ready_i;
      if (held_valid && out_valid_o !== 1'b1) begin
        $display("Output valid dropped before the item was taken");
        error_count++;
      end else if (held_valid) begin
        check_fetch("out_o (held)", out_o, held_item);
      end
      if (took) begin
        exp_item = '{instr: image[img_idx(exp_pc)], pc: exp_pc};
        check_fetch("out_o", out_o, exp_item);
        taken_count++;
      end
      held_valid = out_valid_o && !out_ready_i;
      held_item  = out_o;
      model_pc   = next_pc(model_pc, took, branch_i, boffset_i, irq_i, drq_i);
      // Next read is issued from the updated PC
      if (took) exp_pc = model_pc;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      error_count++;
      report_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hac65_5639));
    rst_i       = 1'b1;
    irq_i       = 1'b0;
    drq_i       = 1'b0;
    branch_i    = 1'b0;
    boffset_i   = 20'h0;
    out_ready_i = 1'b0;
    lsu_req_i   = 1'b0;
    lsu_we_i    = 1'b0;
    lsu_addr_i  = 32'h0;
    lsu_wdata_i = 32'h0;
    apply_reset();
    // Load the image and read back random wrapping addresses
    fill_ram();
    repeat (64) lsu_read_check($urandom & 32'hffff_fffc);
    // Fresh start from the boot address
    apply_reset();
    stream_items(64, 1'b0);
    stream_items(200, 1'b1);
    repeat (8) redirect_pulse(1'b1, 1'b0, 1'b0);
    // All redirect combinations
    for (int c = 0; c < 8; c++) begin
      redirect_pulse(c[0], c[1], c[2]);
    end
    // Park the stream at the debug vector before the mixed traffic
    redirect_pulse(1'b0, 1'b0, 1'b1);
    fork
      stream_items(100, 1'b1);
      lsu_traffic(60);
    join
    repeat (4) next_cycle();
    report_counts();
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+common
common/bus_pkg.sv
common/core_pkg.sv
fetch/fetch_unit.sv
verilog/load_store_unit.sv
verilog/bus_arbiter.sv
verilog/local_ram.sv
verilog/fetch_subsystem.sv
test/tb_fetch_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_fetch_subsystem
FILELIST  := all.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --assert --timing --top-module $(TOP) --Mdir $(BUILD_DIR)
SIM       := $(BUILD_DIR)/V$(TOP)
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
